// File: src/ext_bridge_pkg.sv
`default_nettype none

package ext_bridge_pkg;

   // Bus widths
   localparam int unsigned ADDR_W    = 32;
   localparam int unsigned DATA_W    = 32;
   localparam int unsigned BE_W      = 4;
   // Two initiator ports, so one id bit
   localparam int unsigned PORT_ID_W = 1;

   // --------------------------------------------------
   // Request word layout, LSB first
   // --------------------------------------------------
   localparam int unsigned REQ_ADDR_LSB  = 0;
   localparam int unsigned REQ_WE_BIT    = REQ_ADDR_LSB + ADDR_W;
   localparam int unsigned REQ_BE_LSB    = REQ_WE_BIT + 1;
   localparam int unsigned REQ_WDATA_LSB = REQ_BE_LSB + BE_W;
   localparam int unsigned REQ_ID_BIT    = REQ_WDATA_LSB + DATA_W;
   localparam int unsigned REQ_W         = REQ_ID_BIT + PORT_ID_W;

   // --------------------------------------------------
   // Response word layout, LSB first
   // --------------------------------------------------
   localparam int unsigned RSP_RDATA_LSB = 0;
   localparam int unsigned RSP_WE_BIT    = RSP_RDATA_LSB + DATA_W;
   localparam int unsigned RSP_ID_BIT    = RSP_WE_BIT + 1;
   localparam int unsigned RSP_W         = RSP_ID_BIT + PORT_ID_W;

endpackage

`default_nettype wire

// File: src/ext_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module ext_buffer #(
   parameter int unsigned DATA_WIDTH   = 32,
   parameter int unsigned BUFFER_DEPTH = 2
) (
   input  wire                    clk_i,
   input  wire                    rst_ni,
   // Write side
   input  wire                    valid_i,
   input  wire  [DATA_WIDTH-1:0]  data_i,
   output logic                   ready_o,
   // Read side
   output logic [DATA_WIDTH-1:0]  data_o,
   output logic                   valid_o,
   input  wire                    ready_i
);

   // Pointer width, at least one bit even for a single entry
   localparam int unsigned PTR_W = (BUFFER_DEPTH == 1) ? 1 : $clog2(BUFFER_DEPTH);
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(BUFFER_DEPTH - 1);
   localparam logic [PTR_W:0]   FULL_CNT = (PTR_W + 1)'(BUFFER_DEPTH);

   // Next slot to write, and slot at the head
   logic [PTR_W-1:0]      ptr_in_q;
   logic [PTR_W-1:0]      ptr_out_q;
   // Number of words held
   logic [PTR_W:0]        count_q;
   logic [DATA_WIDTH-1:0] mem_q [BUFFER_DEPTH];

   logic full;
   logic push;
   logic pop;

   assign full = (count_q == FULL_CNT);
   // A push into a full buffer is refused, even with a pop in the same cycle
   assign push = valid_i && !full;
   assign pop  = valid_o && ready_i;

   // --------------------------------------------------
   // Occupancy and pointers
   // --------------------------------------------------
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         count_q   <= '0;
         ptr_in_q  <= '0;
         ptr_out_q <= '0;
      end
      else
      begin
         // Push and pop together leave the count alone
         if (pop && !push)
            count_q <= count_q - 1'b1;
         else if (push && !pop)
            count_q <= count_q + 1'b1;

         // Wrap at the last slot
         if (push)
            ptr_in_q <= (ptr_in_q == LAST_PTR) ? '0 : ptr_in_q + 1'b1;
         if (pop)
            ptr_out_q <= (ptr_out_q == LAST_PTR) ? '0 : ptr_out_q + 1'b1;
      end
   end

   // Storage
   always_ff @(posedge clk_i)
   begin
      if (push)
         mem_q[ptr_in_q] <= data_i;
   end

   // Head word is visible as soon as it is counted
   assign data_o  = mem_q[ptr_out_q];
   assign valid_o = (count_q != '0);
   assign ready_o = !full;

endmodule

`default_nettype wire

// File: src/ext_port_mux.sv
`timescale 1ns/10ps
`default_nettype none

module ext_port_mux (
   input  wire                                clk_i,
   input  wire                                rst_ni,
   // Initiator port 0 requests
   input  wire                                p0_req_valid_i,
   input  wire  [ext_bridge_pkg::ADDR_W-1:0]  p0_addr_i,
   input  wire                                p0_we_i,
   input  wire  [ext_bridge_pkg::BE_W-1:0]    p0_be_i,
   input  wire  [ext_bridge_pkg::DATA_W-1:0]  p0_wdata_i,
   output logic                               p0_req_ready_o,
   // Initiator port 1 requests
   input  wire                                p1_req_valid_i,
   input  wire  [ext_bridge_pkg::ADDR_W-1:0]  p1_addr_i,
   input  wire                                p1_we_i,
   input  wire  [ext_bridge_pkg::BE_W-1:0]    p1_be_i,
   input  wire  [ext_bridge_pkg::DATA_W-1:0]  p1_wdata_i,
   output logic                               p1_req_ready_o,
   // Toward the request buffer
   output logic                               req_valid_o,
   output logic [ext_bridge_pkg::REQ_W-1:0]   req_data_o,
   input  wire                                req_ready_i,
   // From the response buffer
   input  wire                                rsp_valid_i,
   input  wire  [ext_bridge_pkg::RSP_W-1:0]   rsp_data_i,
   output logic                               rsp_ready_o,
   // Responses back to the initiators
   output logic                               p0_rsp_valid_o,
   output logic [ext_bridge_pkg::DATA_W-1:0]  p0_rsp_rdata_o,
   output logic                               p0_rsp_we_o,
   input  wire                                p0_rsp_ready_i,
   output logic                               p1_rsp_valid_o,
   output logic [ext_bridge_pkg::DATA_W-1:0]  p1_rsp_rdata_o,
   output logic                               p1_rsp_we_o,
   input  wire                                p1_rsp_ready_i
);

   import ext_bridge_pkg::*;

   localparam logic [PORT_ID_W-1:0] ID_P0 = '0;
   localparam logic [PORT_ID_W-1:0] ID_P1 = PORT_ID_W'(1);

   // Port that wins when both request
   logic [PORT_ID_W-1:0] prio_q;
   logic [PORT_ID_W-1:0] sel;
   logic [PORT_ID_W-1:0] rsp_id;

   // --------------------------------------------------
   // Request arbitration
   // --------------------------------------------------
   always_comb
   begin
      if (p0_req_valid_i && p1_req_valid_i)
         sel = prio_q;
      else if (p1_req_valid_i)
         sel = ID_P1;
      else
         sel = ID_P0;
   end

   assign req_valid_o    = p0_req_valid_i || p1_req_valid_i;
   // Losing port sees ready low
   assign p0_req_ready_o = req_ready_i && (sel == ID_P0);
   assign p1_req_ready_o = req_ready_i && (sel == ID_P1);

   // After each accepted request the other port gets priority
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
         prio_q <= ID_P0;
      else if (req_valid_o && req_ready_i)
         prio_q <= ~sel;
   end

   // Pack granted fields plus the port id
   always_comb
   begin
      req_data_o = '0;
      req_data_o[REQ_ADDR_LSB +: ADDR_W]  = (sel == ID_P1) ? p1_addr_i : p0_addr_i;
      req_data_o[REQ_WE_BIT]              = (sel == ID_P1) ? p1_we_i : p0_we_i;
      req_data_o[REQ_BE_LSB +: BE_W]      = (sel == ID_P1) ? p1_be_i : p0_be_i;
      req_data_o[REQ_WDATA_LSB +: DATA_W] = (sel == ID_P1) ? p1_wdata_i : p0_wdata_i;
      req_data_o[REQ_ID_BIT +: PORT_ID_W] = sel;
   end

   // --------------------------------------------------
   // Response steering by id
   // --------------------------------------------------
   assign rsp_id = rsp_data_i[RSP_ID_BIT +: PORT_ID_W];

   assign p0_rsp_valid_o = rsp_valid_i && (rsp_id == ID_P0);
   assign p1_rsp_valid_o = rsp_valid_i && (rsp_id == ID_P1);
   // Payload goes to both, only the addressed port sees valid
   assign p0_rsp_rdata_o = rsp_data_i[RSP_RDATA_LSB +: DATA_W];
   assign p1_rsp_rdata_o = rsp_data_i[RSP_RDATA_LSB +: DATA_W];
   assign p0_rsp_we_o    = rsp_data_i[RSP_WE_BIT];
   assign p1_rsp_we_o    = rsp_data_i[RSP_WE_BIT];

   assign rsp_ready_o = (rsp_id == ID_P1) ? p1_rsp_ready_i : p0_rsp_ready_i;

endmodule

`default_nettype wire

// File: src/ext_wb_master.sv
`timescale 1ns/10ps
`default_nettype none

module ext_wb_master (
   input  wire                                clk_i,
   input  wire                                rst_ni,
   // Head of the request buffer
   input  wire                                req_valid_i,
   input  wire  [ext_bridge_pkg::REQ_W-1:0]   req_data_i,
   output logic                               req_ready_o,
   // Into the response buffer
   output logic                               rsp_valid_o,
   output logic [ext_bridge_pkg::RSP_W-1:0]   rsp_data_o,
   input  wire                                rsp_ready_i,
   // Wishbone classic master
   output logic                               wb_cyc_o,
   output logic                               wb_stb_o,
   output logic                               wb_we_o,
   output logic [ext_bridge_pkg::ADDR_W-1:0]  wb_adr_o,
   output logic [ext_bridge_pkg::BE_W-1:0]    wb_sel_o,
   output logic [ext_bridge_pkg::DATA_W-1:0]  wb_dat_o,
   input  wire  [ext_bridge_pkg::DATA_W-1:0]  wb_dat_i,
   input  wire                                wb_ack_i
);

   import ext_bridge_pkg::*;

   localparam logic S_IDLE = 1'b0;
   localparam logic S_BUSY = 1'b1;

   logic                 state_q;
   logic                 state_d;
   logic                 start;
   logic                 done;
   // Issuing port of the transfer in flight
   logic [PORT_ID_W-1:0] id_q;
   logic [DATA_W-1:0]    rdata;

   // Only start when the response has somewhere to go
   assign start = (state_q == S_IDLE) && req_valid_i && rsp_ready_i;
   assign done  = (state_q == S_BUSY) && wb_ack_i;

   // --------------------------------------------------
   // Idle / busy FSM
   // --------------------------------------------------
   always_comb
   begin
      state_d = state_q;
      if (start)
         state_d = S_BUSY;
      else if (done)
         state_d = S_IDLE;
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
         state_q <= S_IDLE;
      else
         state_q <= state_d;
   end

   // Bus fields latched from the head as the cycle opens
   always_ff @(posedge clk_i)
   begin
      if (start)
      begin
         wb_adr_o <= req_data_i[REQ_ADDR_LSB +: ADDR_W];
         wb_we_o  <= req_data_i[REQ_WE_BIT];
         wb_sel_o <= req_data_i[REQ_BE_LSB +: BE_W];
         wb_dat_o <= req_data_i[REQ_WDATA_LSB +: DATA_W];
         id_q     <= req_data_i[REQ_ID_BIT +: PORT_ID_W];
      end
   end

   // cyc and stb together for the whole busy state
   assign wb_cyc_o = (state_q == S_BUSY);
   assign wb_stb_o = (state_q == S_BUSY);

   // --------------------------------------------------
   // Completion
   // --------------------------------------------------
   // Pop the request and push the response on the ack cycle
   assign req_ready_o = done;
   assign rsp_valid_o = done;

   // Writes report zero data
   assign rdata = wb_we_o ? '0 : wb_dat_i;

   always_comb
   begin
      rsp_data_o = '0;
      rsp_data_o[RSP_RDATA_LSB +: DATA_W]  = rdata;
      rsp_data_o[RSP_WE_BIT]               = wb_we_o;
      rsp_data_o[RSP_ID_BIT +: PORT_ID_W]  = id_q;
   end

endmodule

`default_nettype wire

// File: src/ext_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module ext_bridge #(
   parameter int unsigned REQ_DEPTH = 4,
   parameter int unsigned RSP_DEPTH = 2
) (
   input  wire                                clk_i,
   input  wire                                rst_ni,
   // Initiator port 0
   input  wire                                p0_req_valid_i,
   input  wire  [ext_bridge_pkg::ADDR_W-1:0]  p0_addr_i,
   input  wire                                p0_we_i,
   input  wire  [ext_bridge_pkg::BE_W-1:0]    p0_be_i,
   input  wire  [ext_bridge_pkg::DATA_W-1:0]  p0_wdata_i,
   output logic                               p0_req_ready_o,
   output logic                               p0_rsp_valid_o,
   output logic [ext_bridge_pkg::DATA_W-1:0]  p0_rsp_rdata_o,
   output logic                               p0_rsp_we_o,
   input  wire                                p0_rsp_ready_i,
   // Initiator port 1
   input  wire                                p1_req_valid_i,
   input  wire  [ext_bridge_pkg::ADDR_W-1:0]  p1_addr_i,
   input  wire                                p1_we_i,
   input  wire  [ext_bridge_pkg::BE_W-1:0]    p1_be_i,
   input  wire  [ext_bridge_pkg::DATA_W-1:0]  p1_wdata_i,
   output logic                               p1_req_ready_o,
   output logic                               p1_rsp_valid_o,
   output logic [ext_bridge_pkg::DATA_W-1:0]  p1_rsp_rdata_o,
   output logic                               p1_rsp_we_o,
   input  wire                                p1_rsp_ready_i,
   // Wishbone system side
   output logic                               wb_cyc_o,
   output logic                               wb_stb_o,
   output logic                               wb_we_o,
   output logic [ext_bridge_pkg::ADDR_W-1:0]  wb_adr_o,
   output logic [ext_bridge_pkg::BE_W-1:0]    wb_sel_o,
   output logic [ext_bridge_pkg::DATA_W-1:0]  wb_dat_o,
   input  wire  [ext_bridge_pkg::DATA_W-1:0]  wb_dat_i,
   input  wire                                wb_ack_i
);

   import ext_bridge_pkg::*;

   // Arbiter into request buffer
   logic             mux_req_valid;
   logic [REQ_W-1:0] mux_req_data;
   logic             mux_req_ready;
   // Request buffer head into master
   logic             head_req_valid;
   logic [REQ_W-1:0] head_req_data;
   logic             head_req_ready;
   // Master into response buffer
   logic             mst_rsp_valid;
   logic [RSP_W-1:0] mst_rsp_data;
   logic             mst_rsp_ready;
   // Response buffer head back to the arbiter
   logic             head_rsp_valid;
   logic [RSP_W-1:0] head_rsp_data;
   logic             head_rsp_ready;

   ext_port_mux u_port_mux (
      .clk_i, .rst_ni,
      .p0_req_valid_i, .p0_addr_i, .p0_we_i, .p0_be_i, .p0_wdata_i, .p0_req_ready_o,
      .p1_req_valid_i, .p1_addr_i, .p1_we_i, .p1_be_i, .p1_wdata_i, .p1_req_ready_o,
      .req_valid_o (mux_req_valid),
      .req_data_o  (mux_req_data),
      .req_ready_i (mux_req_ready),
      .rsp_valid_i (head_rsp_valid),
      .rsp_data_i  (head_rsp_data),
      .rsp_ready_o (head_rsp_ready),
      .p0_rsp_valid_o, .p0_rsp_rdata_o, .p0_rsp_we_o, .p0_rsp_ready_i,
      .p1_rsp_valid_o, .p1_rsp_rdata_o, .p1_rsp_we_o, .p1_rsp_ready_i
   );

   ext_buffer #(.DATA_WIDTH(REQ_W), .BUFFER_DEPTH(REQ_DEPTH)) u_req_buf (
      .clk_i, .rst_ni,
      .valid_i (mux_req_valid),  .data_i (mux_req_data),  .ready_o (mux_req_ready),
      .data_o  (head_req_data),  .valid_o (head_req_valid), .ready_i (head_req_ready)
   );

   ext_wb_master u_wb_master (
      .clk_i, .rst_ni,
      .req_valid_i (head_req_valid), .req_data_i (head_req_data), .req_ready_o (head_req_ready),
      .rsp_valid_o (mst_rsp_valid),  .rsp_data_o (mst_rsp_data),  .rsp_ready_i (mst_rsp_ready),
      .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_sel_o, .wb_dat_o, .wb_dat_i, .wb_ack_i
   );

   ext_buffer #(.DATA_WIDTH(RSP_W), .BUFFER_DEPTH(RSP_DEPTH)) u_rsp_buf (
      .clk_i, .rst_ni,
      .valid_i (mst_rsp_valid),  .data_i (mst_rsp_data),  .ready_o (mst_rsp_ready),
      .data_o  (head_rsp_data),  .valid_o (head_rsp_valid), .ready_i (head_rsp_ready)
   );

endmodule

`default_nettype wire

// File: dv/tb_wb_memory.sv
`timescale 1ns/10ps
`default_nettype none

module tb_wb_memory #(
   parameter int SEED = 1
) (
   input  wire                                clk_i,
   input  wire                                rst_ni,
   input  wire                                cyc_i,
   input  wire                                stb_i,
   input  wire                                we_i,
   input  wire  [ext_bridge_pkg::ADDR_W-1:0]  adr_i,
   input  wire  [ext_bridge_pkg::BE_W-1:0]    sel_i,
   input  wire  [ext_bridge_pkg::DATA_W-1:0]  dat_i,
   output logic [ext_bridge_pkg::DATA_W-1:0]  dat_o,
   output logic                               ack_o
);

   import ext_bridge_pkg::*;

   // Sparse storage keyed by word address
   logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
   logic [ADDR_W-1:0] key;
   logic [DATA_W-1:0] word;
   int                seed;

   initial seed = SEED;

   // Unwritten words read back a pattern of their full address
   function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
      return (a * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
   endfunction

   // --------------------------------------------------
   // Classic slave, one ack per strobe
   // --------------------------------------------------
   always @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         ack_o <= 1'b0;
         dat_o <= '0;
      end
      else
      begin
         ack_o <= 1'b0;
         // Roughly one wait state in four
         if (cyc_i && stb_i && !ack_o && (($random(seed) & 3) != 0))
         begin
            key  = {adr_i[ADDR_W-1:2], 2'b00};
            word = mem.exists(key) ? mem[key] : fill_word(key);
            if (we_i)
            begin
               for (int i = 0; i < BE_W; i++)
                  if (sel_i[i])
                     word[8*i +: 8] = dat_i[8*i +: 8];
               mem[key] = word;
            end
            dat_o <= word;
            ack_o <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: dv/tb_ext_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ext_bridge;

   import ext_bridge_pkg::*;

   localparam int SEED          = 19264;
   localparam int HALF_PERIOD   = 10;
   localparam int RESET_CYCLES  = 5;
   localparam int NUM_TXN       = 40;
   localparam int RR_TXN        = 16;
   localparam int STALL_TXN     = 12;
   localparam int STALL_CYCLES  = 40;
   localparam int PHASE_TIMEOUT = 2000;
   localparam int DRAIN_TIMEOUT = 500;

   logic clk = 1'b0;
   logic rst_n;

   // Initiator side indexed by port number
   logic [1:0]             req_valid;
   logic [1:0]             req_ready;
   logic [1:0]             req_we;
   logic [1:0][ADDR_W-1:0] req_addr;
   logic [1:0][BE_W-1:0]   req_be;
   logic [1:0][DATA_W-1:0] req_wdata;
   logic [1:0]             rsp_valid;
   logic [1:0]             rsp_ready;
   logic [1:0]             rsp_we;
   logic [1:0][DATA_W-1:0] rsp_rdata;

   // Wishbone between bridge and memory
   logic              wb_cyc;
   logic              wb_stb;
   logic              wb_we;
   logic [ADDR_W-1:0] wb_adr;
   logic [BE_W-1:0]   wb_sel;
   logic [DATA_W-1:0] wb_dat_w;
   logic [DATA_W-1:0] wb_dat_r;
   logic              wb_ack;

   // Reference model state
   logic [DATA_W-1:0] shadow [logic [ADDR_W-1:0]];
   // Expected responses with the write flag above the data
   logic [DATA_W:0]   exp_q0[$];
   logic [DATA_W:0]   exp_q1[$];
   logic              prio_m;
   int                issued [2];
   int                stall_left;
   bit                saw_full;
   bit                timed_out;
   int                seed;
   int                checks;
   int                errors;

   always #HALF_PERIOD clk = ~clk;

   ext_bridge #(.REQ_DEPTH(4), .RSP_DEPTH(2)) DUT (
      .clk_i (clk), .rst_ni (rst_n),
      .p0_req_valid_i (req_valid[0]), .p0_addr_i (req_addr[0]), .p0_we_i (req_we[0]),
      .p0_be_i (req_be[0]), .p0_wdata_i (req_wdata[0]), .p0_req_ready_o (req_ready[0]),
      .p0_rsp_valid_o (rsp_valid[0]), .p0_rsp_rdata_o (rsp_rdata[0]),
      .p0_rsp_we_o (rsp_we[0]), .p0_rsp_ready_i (rsp_ready[0]),
      .p1_req_valid_i (req_valid[1]), .p1_addr_i (req_addr[1]), .p1_we_i (req_we[1]),
      .p1_be_i (req_be[1]), .p1_wdata_i (req_wdata[1]), .p1_req_ready_o (req_ready[1]),
      .p1_rsp_valid_o (rsp_valid[1]), .p1_rsp_rdata_o (rsp_rdata[1]),
      .p1_rsp_we_o (rsp_we[1]), .p1_rsp_ready_i (rsp_ready[1]),
      .wb_cyc_o (wb_cyc), .wb_stb_o (wb_stb), .wb_we_o (wb_we), .wb_adr_o (wb_adr),
      .wb_sel_o (wb_sel), .wb_dat_o (wb_dat_w), .wb_dat_i (wb_dat_r), .wb_ack_i (wb_ack)
   );

   tb_wb_memory #(.SEED(SEED)) u_mem (
      .clk_i (clk), .rst_ni (rst_n), .cyc_i (wb_cyc), .stb_i (wb_stb), .we_i (wb_we),
      .adr_i (wb_adr), .sel_i (wb_sel), .dat_i (wb_dat_w), .dat_o (wb_dat_r), .ack_o (wb_ack)
   );

   // --------------------------------------------------
   // Compare tasks
   // --------------------------------------------------
   task automatic check_rdata(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   // --------------------------------------------------
   // Reference model
   // --------------------------------------------------
   // Same address pattern the memory starts with
   function automatic logic [DATA_W-1:0] shadow_read(input logic [ADDR_W-1:0] a);
      if (shadow.exists(a))
         return shadow[a];
      return (a * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
   endfunction

   // Requests execute in acceptance order so the model updates here
   task automatic accept_request(input int p);
      logic [DATA_W-1:0] word;
      logic [DATA_W:0]   entry;
      word = shadow_read(req_addr[p]);
      if (req_we[p])
      begin
         // Merge only the enabled bytes
         for (int i = 0; i < BE_W; i++)
            if (req_be[p][i])
               word[8*i +: 8] = req_wdata[p][8*i +: 8];
         shadow[req_addr[p]] = word;
         entry = {1'b1, {DATA_W{1'b0}}};
      end
      else
         entry = {1'b0, word};
      if (p == 0)
         exp_q0.push_back(entry);
      else
         exp_q1.push_back(entry);
   endtask

   task automatic check_response(input int p);
      logic [DATA_W:0] exp;
      if ((p == 0 && exp_q0.size() == 0) || (p == 1 && exp_q1.size() == 0))
      begin
         errors++;
         $display("Port %0d returned a response with no request outstanding", p);
      end
      else
      begin
         if (p == 0)
            exp = exp_q0.pop_front();
         else
            exp = exp_q1.pop_front();
         check_flag($sformatf("port %0d response write flag", p), exp[DATA_W], rsp_we[p]);
         check_rdata($sformatf("port %0d response data", p), exp[DATA_W-1:0], rsp_rdata[p]);
      end
   endtask

   // --------------------------------------------------
   // One clock of monitoring and driving
   // --------------------------------------------------
   task automatic step_cycle(input bit saturate, input int n_req);
      logic [1:0] acc;
      logic       grant;
      int         p;
      // Inputs have settled and handshakes complete at the next edge
      @(negedge clk);
      acc = req_valid & req_ready;
      if (req_valid != 2'b00 && req_ready == 2'b00)
         saw_full = 1'b1;
      if (acc != 2'b00)
      begin
         // Round robin flips priority after every acceptance
         grant = (req_valid == 2'b11) ? prio_m : req_valid[1];
         check_flag("single grant", 1'b1, acc != 2'b11);
         check_flag("granted port", grant, acc[1]);
         accept_request(acc[1] ? 1 : 0);
         prio_m = ~acc[1];
      end
      for (p = 0; p < 2; p++)
         if (rsp_valid[p] && rsp_ready[p])
            check_response(p);

      @(posedge clk);
      #1;
      for (p = 0; p < 2; p++)
      begin
         if (acc[p])
            req_valid[p] = 1'b0;
         // Fields stay put while valid is high
         if (!req_valid[p] && issued[p] < n_req && (saturate || ($random(seed) & 3) != 0))
         begin
            issued[p]++;
            req_valid[p] = 1'b1;
            req_we[p]    = 1'($random(seed));
            req_addr[p]  = 32'h0000_1000 | ((32'($random(seed)) & 32'h7) << 2);
            req_be[p]    = BE_W'($random(seed));
            req_wdata[p] = $random(seed);
         end
         rsp_ready[p] = (stall_left > 0) ? 1'b0 : (saturate || ($random(seed) & 3) != 0);
      end
      if (stall_left > 0)
         stall_left--;
   endtask

   task automatic run_phase(input string name, input bit saturate, input int n_req,
                            input int stall);
      int cycles;
      cycles     = 0;
      issued[0]  = 0;
      issued[1]  = 0;
      stall_left = stall;
      while (!timed_out && (issued[0] < n_req || issued[1] < n_req || req_valid != 2'b00))
      begin
         step_cycle(saturate, n_req);
         cycles++;
         if (cycles > PHASE_TIMEOUT)
         begin
            $display("Timeout: %s phase did not get all requests accepted", name);
            timed_out = 1'b1;
         end
      end
   endtask

   // Wait without new requests until every response is back
   task automatic drain(input string name);
      int cycles;
      cycles = 0;
      while (!timed_out && (exp_q0.size() != 0 || exp_q1.size() != 0))
      begin
         step_cycle(1'b0, 0);
         cycles++;
         if (cycles > DRAIN_TIMEOUT)
         begin
            $display("Timeout: %s phase left responses outstanding", name);
            timed_out = 1'b1;
         end
      end
   endtask

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------
   initial
   begin
      seed       = SEED;
      checks     = 0;
      errors     = 0;
      timed_out  = 1'b0;
      saw_full   = 1'b0;
      prio_m     = 1'b0;
      stall_left = 0;
      rst_n      = 1'b0;
      req_valid  = '0;
      req_we     = '0;
      req_addr   = '0;
      req_be     = '0;
      req_wdata  = '0;
      rsp_ready  = '0;

      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;

      // Idle outputs before any stimulus
      @(negedge clk);
      check_flag("p0 response valid after reset", 1'b0, rsp_valid[0]);
      check_flag("p1 response valid after reset", 1'b0, rsp_valid[1]);
      check_flag("wb cyc after reset", 1'b0, wb_cyc);
      check_flag("wb stb after reset", 1'b0, wb_stb);

      // Random traffic with random response ready and wait states
      run_phase("random", 1'b0, NUM_TXN, 0);
      drain("random");

      // Both ports always requesting
      run_phase("round robin", 1'b1, RR_TXN, 0);
      drain("round robin");

      // Responses held off until the request buffer fills
      saw_full = 1'b0;
      run_phase("back-pressure", 1'b1, STALL_TXN, STALL_CYCLES);
      drain("back-pressure");
      if (!timed_out)
         check_flag("request ready fell under back-pressure", 1'b1, saw_full);

      // Nothing extra may show up once drained
      repeat (10) step_cycle(1'b0, 0);

      $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
      if (errors == 0 && !timed_out)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: ext_bridge.f
src/ext_bridge_pkg.sv
src/ext_buffer.sv
src/ext_port_mux.sv
src/ext_wb_master.sv
src/ext_bridge.sv
dv/tb_wb_memory.sv
dv/tb_ext_bridge.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_ext_bridge
FILELIST  = ext_bridge.f
PASS_MSG  = Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
